// File: branchDecodeTop.f
+incdir+include
design/branchPkg.sv
design/decodeRegFile.sv
design/branchJudge.sv
design/branchTarget.sv
design/fetchPc.sv
design/branchDecodeTop.sv
dv/branchDecode_props.sv
dv/branchDecodeTb.sv

// File: dv/branchDecodeTb.sv
`timescale 1ns/100ps
`include "branch_cfg.svh"

module branchDecodeTb;
    import branchPkg::*;

    localparam int TIMEOUT_NS = 500000;

    logic     clk;
    logic     rst;
    logic     instrValid;
    word_t    instr;
    logic     wbEn;
    regAddr_t wbAddr;
    word_t    wbData;
    word_t    pc;
    logic     taken;
    word_t    nextPc;
    word_t    rsValue;
    word_t    rtValue;

    // reference state
    word_t modelRegs [32];
    word_t modelPc;

    branchDecodeTop i_branchDecodeTop (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .wbEn       (wbEn),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .pc         (pc),
        .taken      (taken),
        .nextPc     (nextPc),
        .rsValue    (rsValue),
        .rtValue    (rtValue)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopOnFailure();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish in time");
        stopOnFailure();
    end

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            stopOnFailure();
        end
    endtask

    function automatic word_t encodeI(input logic [5:0] op, input regAddr_t rs,
                                      input regAddr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encodeR(input regAddr_t rs, input regAddr_t rt,
                                      input regAddr_t rd, input logic [5:0] funct);
        return {`OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    // mix of zero, negative, positive and anything
    function automatic word_t randomValue();
        word_t r;
        r = $urandom;
        case ($urandom % 4)
            0: return '0;
            1: return r | 32'h8000_0000;
            2: return r & 32'h7fff_ffff;
            default: return r;
        endcase
    endfunction

    function automatic word_t condBranch(input int kind, input regAddr_t rs,
                                         input regAddr_t rt, input logic [15:0] imm);
        case (kind)
            0: return encodeI(`OP_BEQ, rs, rt, imm);
            1: return encodeI(`OP_BNE, rs, rt, imm);
            2: return encodeI(`OP_REGIMM, rs, `RT_BGEZ, imm);
            3: return encodeI(`OP_REGIMM, rs, `RT_BLTZ, imm);
            4: return encodeI(`OP_BGTZ, rs, 5'd0, imm);
            default: return encodeI(`OP_BLEZ, rs, 5'd0, imm);
        endcase
    endfunction

    function automatic word_t randomInstr();
        word_t a;
        word_t b;
        a = $urandom;
        b = $urandom;
        case ($urandom % 8)
            0, 1: return condBranch($urandom % 6, a[4:0], a[9:5], b[15:0]);
            2: return encodeI(`OP_REGIMM, a[4:0], a[9:5], b[15:0]);
            3: return {(a[31] ? `OP_JAL : `OP_J), b[25:0]};
            4: return encodeR(a[4:0], 5'd0, a[9:5], (a[31] ? `FN_JALR : `FN_JR));
            5: return encodeR(a[4:0], a[9:5], a[14:10], b[5:0]);
            default: return a;
        endcase
    endfunction

    function automatic word_t modelRead(input regAddr_t addr, input logic we,
                                        input regAddr_t wa, input word_t wd);
        if (addr == 5'd0) return '0;
        if (we && wa == addr) return wd;
        return modelRegs[addr];
    endfunction

    // branch rules of the ISA
    task automatic modelDecode(input word_t ins, input word_t rsV, input word_t rtV,
                               input word_t curPc, output logic tk, output word_t npc,
                               output logic lk, output regAddr_t lAddr);
        word_t pc4;
        word_t tgt;
        pc4   = curPc + 32'd4;
        tgt   = pc4 + {{14{ins[15]}}, ins[15:0], 2'b00};
        tk    = 1'b0;
        lk    = 1'b0;
        lAddr = `LINK_REG;
        case (ins[31:26])
            `OP_BEQ: tk = rsV == rtV;
            `OP_BNE: tk = rsV != rtV;
            `OP_BGTZ: tk = ins[20:16] == 5'd0 && $signed(rsV) > 0;
            `OP_BLEZ: tk = ins[20:16] == 5'd0 && $signed(rsV) <= 0;
            `OP_REGIMM: begin
                if (ins[20:16] == `RT_BGEZ || ins[20:16] == `RT_BGEZAL) tk = $signed(rsV) >= 0;
                if (ins[20:16] == `RT_BLTZ || ins[20:16] == `RT_BLTZAL) tk = $signed(rsV) < 0;
                lk = tk && ins[20];
            end
            `OP_J, `OP_JAL: begin
                tk  = 1'b1;
                lk  = ins[26];
                tgt = {pc4[31:28], ins[25:0], 2'b00};
            end
            `OP_SPECIAL: begin
                if (ins[5:0] == `FN_JR || ins[5:0] == `FN_JALR) begin
                    tk    = 1'b1;
                    lk    = ins[5:0] == `FN_JALR;
                    lAddr = ins[15:11];
                    tgt   = {rsV[31:2], 2'b00};
                end
            end
            default: ;
        endcase
        npc = tk ? tgt : pc4;
    endtask

    // one clock of stimulus checked against the model before the next edge
    task automatic runCycle(input string name, input logic valid, input word_t ins,
                            input logic we, input regAddr_t wa, input word_t wd);
        word_t    expRs;
        word_t    expRt;
        word_t    expNext;
        logic     expTaken;
        logic     lk;
        regAddr_t la;
        @(posedge clk);
        #1;
        instrValid = valid;
        instr      = ins;
        wbEn       = we;
        wbAddr     = wa;
        wbData     = wd;
        #2;
        checkValue({name, " pc"}, modelPc, pc);
        expRs = modelRead(ins[25:21], we, wa, wd);
        expRt = modelRead(ins[20:16], we, wa, wd);
        checkValue({name, " rsValue"}, expRs, rsValue);
        checkValue({name, " rtValue"}, expRt, rtValue);
        modelDecode(ins, expRs, expRt, modelPc, expTaken, expNext, lk, la);
        checkValue({name, " taken"}, valid && expTaken, taken);
        if (valid) begin
            checkValue({name, " nextPc"}, expNext, nextPc);
        end
        // link write beats the external port
        if (valid && lk) begin
            if (la != 5'd0) modelRegs[la] = modelPc + 32'd8;
        end else if (we && wa != 5'd0) begin
            modelRegs[wa] = wd;
        end
        if (valid) modelPc = expNext;
    endtask

    task automatic loadReg(input regAddr_t addr, input word_t value);
        runCycle("load", 1'b0, '0, 1'b1, addr, value);
    endtask

    task automatic waitResetPc();
        int cycles;
        cycles = 0;
        while (pc !== `RESET_PC) begin
            @(posedge clk);
            cycles++;
            if (cycles > 8) begin
                $display("pc never reached the reset address after reset");
                stopOnFailure();
            end
        end
    endtask

    initial begin
        word_t    seedValue;
        word_t    rnd;
        word_t    linkPc;
        regAddr_t rsA;
        regAddr_t rtA;
        regAddr_t rdA;
        int       idle;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        wbEn       = 1'b0;
        wbAddr     = '0;
        wbData     = '0;
        seedValue  = $urandom(32'ha112);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        waitResetPc();
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        modelPc = `RESET_PC;

        // reset state
        checkValue("reset taken", 32'd0, taken);
        for (int i = 0; i < 32; i++) begin
            runCycle("reset regs", 1'b0, encodeI(`OP_BEQ, i[4:0], 5'd31 - i[4:0], 16'd0),
                     1'b0, '0, '0);
        end

        // conditional branches
        for (int n = 0; n < 120; n++) begin
            rnd = $urandom;
            rsA = 5'd1 + rnd[4:0] % 5'd30;
            rtA = 5'd1 + rnd[9:5] % 5'd30;
            linkPc = randomValue();
            loadReg(rsA, linkPc);
            loadReg(rtA, rnd[31:30] == 2'b00 ? linkPc : randomValue());
            runCycle("cond branch", 1'b1, condBranch($urandom % 6, rsA, rtA, rnd[31:16]),
                     1'b0, '0, '0);
        end

        // jumps and plain op-0 fall through
        for (int n = 0; n < 40; n++) begin
            rnd = $urandom;
            rsA = 5'd1 + rnd[4:0] % 5'd30;
            rdA = 5'd1 + rnd[9:5] % 5'd30;
            loadReg(rsA, $urandom);
            linkPc = modelPc;
            case (n % 5)
                0: runCycle("j", 1'b1, {`OP_J, rnd[31:6]}, 1'b0, '0, '0);
                1: runCycle("jal", 1'b1, {`OP_JAL, rnd[31:6]}, 1'b0, '0, '0);
                2: runCycle("jr", 1'b1, encodeR(rsA, 5'd0, 5'd0, `FN_JR), 1'b0, '0, '0);
                3: runCycle("jalr", 1'b1, encodeR(rsA, 5'd0, rdA, `FN_JALR), 1'b0, '0, '0);
                default: begin
                    rnd[5:0] = (rnd[5:1] == 5'b00100) ? 6'h20 : rnd[5:0];
                    runCycle("op0 other", 1'b1, encodeR(rsA, rdA, rdA, rnd[5:0]),
                             1'b0, '0, '0);
                end
            endcase
            if (n % 5 == 1) begin
                runCycle("jal readback", 1'b0, encodeR(`LINK_REG, 5'd0, 5'd0, 6'd0),
                         1'b0, '0, '0);
                checkValue("jal link", linkPc + 32'd8, rsValue);
            end else if (n % 5 == 3) begin
                runCycle("jalr readback", 1'b0, encodeR(rdA, 5'd0, 5'd0, 6'd0),
                         1'b0, '0, '0);
                checkValue("jalr link", linkPc + 32'd8, rsValue);
            end
        end

        // linking branches taken or not
        for (int n = 0; n < 30; n++) begin
            loadReg(5'd5, randomValue());
            loadReg(`LINK_REG, $urandom);
            rnd = $urandom;
            runCycle("link branch", 1'b1,
                     encodeI(`OP_REGIMM, 5'd5, rnd[0] ? `RT_BGEZAL : `RT_BLTZAL, rnd[31:16]),
                     1'b0, '0, '0);
            runCycle("link readback", 1'b0, encodeR(`LINK_REG, 5'd0, 5'd0, 6'd0),
                     1'b0, '0, '0);
        end

        // r0 stays zero and a write reaches the read port in the same cycle
        runCycle("r0 write", 1'b0, encodeI(`OP_BEQ, 5'd0, 5'd0, 16'd0), 1'b1, 5'd0, $urandom);
        runCycle("r0 read", 1'b0, encodeI(`OP_BEQ, 5'd0, 5'd0, 16'd0), 1'b0, '0, '0);
        for (int n = 0; n < 16; n++) begin
            rnd = $urandom;
            rdA = 5'd1 + rnd[4:0] % 5'd31;
            rnd = $urandom;
            runCycle("bypass", 1'b0, encodeI(`OP_BEQ, rdA, rdA, 16'd0), 1'b1, rdA, rnd);
            checkValue("bypass read", rnd, rsValue);
            runCycle("bypass hold", 1'b0, encodeI(`OP_BEQ, rdA, 5'd0, 16'd0), 1'b0, '0, '0);
        end

        // random program with idle write cycles
        for (int n = 0; n < 2000; n++) begin
            idle = $urandom % 3;
            for (int k = 0; k < idle; k++) begin
                rnd = $urandom;
                runCycle("idle write", 1'b0, $urandom, rnd[5], rnd[4:0], randomValue());
            end
            runCycle("random program", 1'b1, randomInstr(), 1'b0, '0, '0);
        end
        runCycle("final", 1'b0, '0, 1'b0, '0, '0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: dv/branchDecode_props.sv
`timescale 1ns/100ps
`include "branch_cfg.svh"

module branchDecodeProps (
    input logic                clk,
    input logic                rst,
    input branchPkg::word_t    pc,
    input branchPkg::regAddr_t rsAddr,
    input branchPkg::word_t    rsValue
);

    // fetch addresses are whole words
    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc is not word aligned: %h", pc);

    // first cycle out of reset starts at the boot address
    resetPc: assert property (@(posedge clk) rst |=> pc == `RESET_PC)
        else $error("pc after reset is %h", pc);

    r0Zero: assert property (@(posedge clk) disable iff (rst)
            rsAddr == 5'd0 |-> rsValue == 32'd0)
        else $error("r0 read back nonzero: %h", rsValue);

endmodule

bind branchDecodeTop branchDecodeProps i_branchDecodeProps (
    .clk     (clk),
    .rst     (rst),
    .pc      (pc),
    .rsAddr  (fields.rs),
    .rsValue (rsValue)
);

// File: design/branchDecodeTop.sv
`timescale 1ns/100ps

module branchDecodeTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                instrValid,
    input  branchPkg::word_t    instr,
    input  logic                wbEn,
    input  branchPkg::regAddr_t wbAddr,
    input  branchPkg::word_t    wbData,
    output branchPkg::word_t    pc,
    output logic                taken,
    output branchPkg::word_t    nextPc,
    output branchPkg::word_t    rsValue,
    output branchPkg::word_t    rtValue
);
    import branchPkg::*;

    instrFields_t    fields;
    branchDecision_t decision;
    word_t           linkValue;
    logic            linkEn;

    // every format decoded at once, the judge picks what it needs
    assign fields = '{
        op:     instr[31:26],
        rs:     instr[25:21],
        rt:     instr[20:16],
        rd:     instr[15:11],
        imm:    instr[15:0],
        jIndex: instr[25:0],
        funct:  instr[5:0]
    };

    assign taken  = instrValid && decision.taken;
    assign linkEn = instrValid && decision.linkWrite;

    decodeRegFile i_decodeRegFile (
        .clk      (clk),
        .rst      (rst),
        .rsAddr   (fields.rs),
        .rtAddr   (fields.rt),
        .linkEn   (linkEn),
        .linkAddr (decision.linkAddr),
        .linkData (linkValue),
        .wbEn     (wbEn),
        .wbAddr   (wbAddr),
        .wbData   (wbData),
        .rsValue  (rsValue),
        .rtValue  (rtValue)
    );

    branchJudge i_branchJudge (
        .fields   (fields),
        .rsValue  (rsValue),
        .rtValue  (rtValue),
        .decision (decision)
    );

    branchTarget i_branchTarget (
        .pc        (pc),
        .fields    (fields),
        .rsValue   (rsValue),
        .decision  (decision),
        .nextPc    (nextPc),
        .linkValue (linkValue)
    );

    fetchPc i_fetchPc (
        .clk     (clk),
        .rst     (rst),
        .advance (instrValid),
        .nextPc  (nextPc),
        .pc      (pc)
    );

endmodule

// File: design/fetchPc.sv
`timescale 1ns/100ps
`include "branch_cfg.svh"

module fetchPc (
    input  logic             clk,
    input  logic             rst,
    input  logic             advance,
    input  branchPkg::word_t nextPc,
    output branchPkg::word_t pc
);

    // one step per retired instruction, holds otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (advance) begin
            pc <= nextPc;
        end
    end

endmodule

// File: design/branchTarget.sv
`timescale 1ns/100ps

module branchTarget (
    input  branchPkg::word_t           pc,
    input  branchPkg::instrFields_t    fields,
    input  branchPkg::word_t           rsValue,
    input  branchPkg::branchDecision_t decision,
    output branchPkg::word_t           nextPc,
    output branchPkg::word_t           linkValue
);
    import branchPkg::*;

    word_t pcPlus4;
    word_t pcRelTarget;
    word_t jumpTarget;
    word_t regTarget;

    assign pcPlus4 = pc + 32'd4;

    // word offset from the delay slot address
    assign pcRelTarget = pcPlus4 + {{14{fields.imm[15]}}, fields.imm, 2'b00};

    // stays inside the current 256 MB region
    assign jumpTarget = {pcPlus4[31:28], fields.jIndex, 2'b00};

    assign regTarget = {rsValue[31:2], 2'b00};

    // return address skips the delay slot
    assign linkValue = pc + 32'd8;

    always_comb begin
        if (!decision.taken) begin
            nextPc = pcPlus4;
        end else begin
            case (decision.sel)
                SEL_PCREL: begin
                    nextPc = pcRelTarget;
                end
                SEL_JINDEX: begin
                    nextPc = jumpTarget;
                end
                SEL_REG: begin
                    nextPc = regTarget;
                end
                default: begin
                    nextPc = pcPlus4;
                end
            endcase
        end
    end

endmodule

// File: design/branchJudge.sv
`timescale 1ns/100ps
`include "branch_cfg.svh"

module branchJudge (
    input  branchPkg::instrFields_t    fields,
    input  branchPkg::word_t           rsValue,
    input  branchPkg::word_t           rtValue,
    output branchPkg::branchDecision_t decision
);
    import branchPkg::*;

    logic signed [31:0] rsSigned;
    logic               rsGez;
    logic               rsGtz;

    assign rsSigned = rsValue;
    assign rsGez    = rsSigned >= 0;
    assign rsGtz    = rsSigned > 0;

    always_comb begin
        decision          = '0;
        decision.sel      = SEL_SEQ;
        decision.linkAddr = `LINK_REG;

        case (fields.op)
            `OP_BEQ: begin
                decision.sel   = SEL_PCREL;
                decision.taken = rsValue == rtValue;
            end
            `OP_BNE: begin
                decision.sel   = SEL_PCREL;
                decision.taken = rsValue != rtValue;
            end
            `OP_REGIMM: begin
                case (fields.rt)
                    `RT_BGEZ: begin
                        decision.sel   = SEL_PCREL;
                        decision.taken = rsGez;
                    end
                    `RT_BLTZ: begin
                        decision.sel   = SEL_PCREL;
                        decision.taken = !rsGez;
                    end
                    `RT_BGEZAL: begin
                        decision.sel       = SEL_PCREL;
                        decision.taken     = rsGez;
                        decision.linkWrite = rsGez;
                    end
                    `RT_BLTZAL: begin
                        decision.sel       = SEL_PCREL;
                        decision.taken     = !rsGez;
                        decision.linkWrite = !rsGez;
                    end
                    default: ;
                endcase
            end
            // rt must be zero for these two
            `OP_BGTZ: begin
                decision.sel   = SEL_PCREL;
                decision.taken = fields.rt == '0 && rsGtz;
            end
            `OP_BLEZ: begin
                decision.sel   = SEL_PCREL;
                decision.taken = fields.rt == '0 && !rsGtz;
            end
            `OP_J: begin
                decision.sel   = SEL_JINDEX;
                decision.taken = 1'b1;
            end
            `OP_JAL: begin
                decision.sel       = SEL_JINDEX;
                decision.taken     = 1'b1;
                decision.linkWrite = 1'b1;
            end
            `OP_SPECIAL: begin
                if (fields.funct == `FN_JR) begin
                    decision.sel   = SEL_REG;
                    decision.taken = 1'b1;
                end else if (fields.funct == `FN_JALR) begin
                    decision.sel       = SEL_REG;
                    decision.taken     = 1'b1;
                    decision.linkWrite = 1'b1;
                    decision.linkAddr  = fields.rd;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: design/decodeRegFile.sv
`timescale 1ns/100ps

module decodeRegFile (
    input  logic               clk,
    input  logic               rst,
    input  branchPkg::regAddr_t rsAddr,
    input  branchPkg::regAddr_t rtAddr,
    input  logic               linkEn,
    input  branchPkg::regAddr_t linkAddr,
    input  branchPkg::word_t    linkData,
    input  logic               wbEn,
    input  branchPkg::regAddr_t wbAddr,
    input  branchPkg::word_t    wbData,
    output branchPkg::word_t    rsValue,
    output branchPkg::word_t    rtValue
);
    import branchPkg::*;

    word_t regs [32];

    // link write wins, the external write is dropped that cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (linkEn) begin
            if (linkAddr != '0) begin
                regs[linkAddr] <= linkData;
            end
        end else if (wbEn && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    // only the external port is bypassed
    // the link decision is itself derived from these read values
    function automatic word_t readPort(regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wbEn && wbAddr == addr) begin
            return wbData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rsValue = readPort(rsAddr);
    end

    always_comb begin
        rtValue = readPort(rtAddr);
    end

endmodule

// File: design/branchPkg.sv
package branchPkg;

    // datum or byte address
    typedef logic [31:0] word_t;

    // register number
    typedef logic [4:0] regAddr_t;

    // instruction field widths
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;
    typedef logic [25:0] jIndex_t;

    // fields overlap in the instruction word, so each is kept separately
    typedef struct packed {
        opcode_t  op;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        imm_t     imm;
        jIndex_t  jIndex;
        funct_t   funct;
    } instrFields_t;

    // where the next pc comes from
    typedef enum logic [1:0] {
        SEL_SEQ,
        SEL_PCREL,
        SEL_JINDEX,
        SEL_REG
    } targetSel_e;

    typedef struct packed {
        logic       taken;
        targetSel_e sel;
        logic       linkWrite;
        regAddr_t   linkAddr;
    } branchDecision_t;

endpackage

// File: include/branch_cfg.svh
`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// first fetch address after reset
`define RESET_PC    32'h0000_3000

// implicit link target for bgezal, bltzal and jal
`define LINK_REG    5'd31

// primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111

// regimm codes carried in the rt field
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define RT_BLTZAL   5'b10000
`define RT_BGEZAL   5'b10001

// register jumps under OP_SPECIAL
`define FN_JR       6'b001000
`define FN_JALR     6'b001001

`endif
